// File: verilog/huff_pkg.sv
package huff_pkg;

    // Encoder phases, stepped by encode_ctrl
    typedef enum logic [2:0] {
        idle      = 3'd0,                   // Waiting for start
        header    = 3'd1,                   // Magic word bits
        translate = 3'd2,                   // Count bits, then code words
        flush     = 3'd3,                   // Pad and send last partial byte
        done      = 3'd4                    // Stream complete
    } phase_t;

    // Character and output byte width
    parameter int char_w = 8;

    // Path word: code bits below a leading marker one
    parameter int path_w = 128;
    parameter int path_idx_w = $clog2(path_w);

    // Total character count in the stream header
    parameter int count_w = 32;
    parameter int count_idx_w = $clog2(count_w);

    // End of file, never encoded
    parameter logic [char_w-1:0] eof_char = 8'h1A;

endpackage

// File: verilog/encode_ctrl.sv
`timescale 1ns/1ps

module encode_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             header_done,
    input  logic             fin,
    input  logic             flushed,
    output huff_pkg::phase_t phase,
    output logic             done
);

    huff_pkg::phase_t phase_n;

    always_comb begin
        phase_n = phase;
        case (phase)
            huff_pkg::idle:      if (start) phase_n = huff_pkg::header;
            huff_pkg::header:    if (header_done) phase_n = huff_pkg::translate;
            huff_pkg::translate: if (fin) phase_n = huff_pkg::flush;
            huff_pkg::flush:     if (flushed) phase_n = huff_pkg::done;
            huff_pkg::done:      if (start) phase_n = huff_pkg::header;  // Next stream
            default:             phase_n = huff_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= huff_pkg::idle;
        end else begin
            phase <= phase_n;
        end
    end

    assign done = (phase == huff_pkg::done);

    // A start in the middle of a stream would be lost
    assert property (@(posedge clk) disable iff (rst)
        start |-> (phase == huff_pkg::idle || phase == huff_pkg::done));

endmodule

// File: verilog/header_emitter.sv
`timescale 1ns/1ps

module header_emitter #(
    parameter logic [15:0] magic = 16'h4855
) (
    input  logic             clk,
    input  logic             rst,
    input  huff_pkg::phase_t phase,
    input  logic             head_take,
    output logic             head_bit,
    output logic             head_valid,
    output logic             head_last
);

    logic [3:0] bit_idx;                    // Counts down from 15
    logic       sent;                       // All 16 bits taken

    assign head_valid = (phase == huff_pkg::header) && !sent;
    assign head_bit   = magic[bit_idx];     // MSB first
    assign head_last  = (bit_idx == 4'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_idx <= 4'd15;
            sent    <= 1'b0;
        end else if (phase != huff_pkg::header) begin
            // Rearm for the next stream
            bit_idx <= 4'd15;
            sent    <= 1'b0;
        end else if (head_take) begin
            if (head_last) begin
                sent <= 1'b1;
            end else begin
                bit_idx <= bit_idx - 4'd1;
            end
        end
    end

endmodule

// File: verilog/code_table.sv
`timescale 1ns/1ps

module code_table (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        tbl_we,
    input  logic [huff_pkg::char_w-1:0] tbl_addr,
    input  logic [huff_pkg::path_w-1:0] tbl_path,
    input  logic                        lookup,
    input  logic [huff_pkg::char_w-1:0] char_addr,
    output logic [huff_pkg::path_w-1:0] path,
    output logic                        path_valid
);

    // One path word per character code
    logic [huff_pkg::path_w-1:0] mem [0:(1 << huff_pkg::char_w)-1];

    logic [huff_pkg::char_w-1:0] addr_q;    // Stage 1 address
    logic                        lookup_q;  // Stage 1 valid

    // Loader writes and the two-stage read
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            mem[tbl_addr] <= tbl_path;
        end
        if (lookup) begin
            addr_q <= char_addr;
        end
        path <= mem[addr_q];                // Stage 2 data
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lookup_q   <= 1'b0;
            path_valid <= 1'b0;
        end else begin
            lookup_q   <= lookup;
            path_valid <= lookup_q;         // Two cycles after lookup
        end
    end

    // Table is only loaded while the encoder is idle
    assert property (@(posedge clk) disable iff (rst)
        !(tbl_we && lookup));

endmodule

// File: verilog/code_translator.sv
`timescale 1ns/1ps

module code_translator (
    input  logic                             clk,
    input  logic                             rst,
    input  huff_pkg::phase_t                 phase,
    input  logic [huff_pkg::count_w-1:0]     total_chars,
    input  logic                             start,
    input  logic                             head_bit,
    input  logic                             head_valid,
    input  logic                             head_last,
    output logic                             head_take,
    input  logic                             char_valid,
    input  logic [huff_pkg::char_w-1:0]      char_data,
    output logic                             char_credit,
    output logic                             lookup,
    output logic [huff_pkg::char_w-1:0]      char_addr,
    input  logic [huff_pkg::path_w-1:0]      path,
    input  logic                             path_valid,
    input  logic                             bit_ready,
    output logic                             bit_valid,
    output logic                             bit_data,
    output logic                             header_done,
    output logic                             fin
);

    typedef enum logic [2:0] {
        st_idle,                            // Header forwarding
        st_count,                           // Total count bits
        st_char,                            // Wait for a held character
        st_wait,                            // Table read in flight
        st_emit,                            // Code bits below the marker
        st_fin                              // End of file seen
    } state_t;

    state_t                              state;
    logic [huff_pkg::count_w-1:0]        count_q;
    logic [huff_pkg::count_idx_w-1:0]    cnt_idx;
    logic [huff_pkg::char_w-1:0]         char_q;
    logic                                char_held;
    logic                                eof_held;
    logic [huff_pkg::path_w-1:0]         path_q;
    logic [huff_pkg::path_idx_w-1:0]     bit_idx;
    logic [huff_pkg::path_idx_w-1:0]     lead;      // Marker position
    logic                                xfer;

    assign char_addr   = char_q;
    assign eof_held    = (char_q == huff_pkg::eof_char);
    assign xfer        = bit_valid && bit_ready;
    assign header_done = head_take && head_last;

    // Highest set bit of the returned path word
    always_comb begin
        lead = '0;
        for (int i = 0; i < huff_pkg::path_w; i++) begin
            if (path[i]) begin
                lead = i[huff_pkg::path_idx_w-1:0];
            end
        end
    end

    always_comb begin
        bit_valid = 1'b0;
        bit_data  = 1'b0;
        head_take = 1'b0;
        lookup    = 1'b0;
        fin       = 1'b0;
        case (state)
            st_idle: begin
                if (phase == huff_pkg::header && head_valid) begin
                    bit_valid = 1'b1;
                    bit_data  = head_bit;
                    head_take = bit_ready;
                end
            end
            st_count: begin
                bit_valid = 1'b1;
                bit_data  = count_q[cnt_idx];
            end
            st_char: begin
                if (char_held) begin
                    fin    = eof_held;      // End of file emits nothing
                    lookup = !eof_held;
                end
            end
            st_emit: begin
                bit_valid = 1'b1;
                bit_data  = path_q[bit_idx];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= st_idle;
            char_held   <= 1'b0;
            char_credit <= 1'b0;
        end else begin
            char_credit <= 1'b0;
            case (state)
                st_idle:  if (header_done) state <= st_count;
                st_count: if (xfer && cnt_idx == '0) state <= st_char;
                st_char:  if (char_held) state <= eof_held ? st_fin : st_wait;
                st_wait: begin
                    if (path_valid) begin
                        if (lead == '0) begin   // Empty code
                            state       <= st_char;
                            char_held   <= 1'b0;
                            char_credit <= 1'b1;
                        end else begin
                            state <= st_emit;
                        end
                    end
                end
                st_emit: begin
                    if (xfer && bit_idx == '0) begin
                        state       <= st_char;
                        char_held   <= 1'b0;
                        char_credit <= 1'b1;    // Character consumed
                    end
                end
                default: ;
            endcase
            if (start) begin
                state <= st_idle;
                // The previous end of file is released here
                if (char_held && eof_held) begin
                    char_held   <= 1'b0;
                    char_credit <= 1'b1;
                end
            end
            if (char_valid) begin
                char_held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            count_q <= total_chars;
        end
        if (header_done) begin
            cnt_idx <= '1;                  // Count MSB
        end else if (state == st_count && xfer) begin
            cnt_idx <= cnt_idx - 1'b1;
        end
        if (char_valid) begin
            char_q <= char_data;
        end
        if (state == st_wait && path_valid) begin
            path_q  <= path;
            bit_idx <= lead - 1'b1;         // Skip the marker
        end else if (state == st_emit && xfer) begin
            bit_idx <= bit_idx - 1'b1;
        end
    end

    // Table answers only what was asked two cycles before
    assert property (@(posedge clk) disable iff (rst)
        path_valid |-> $past(lookup, 2));

endmodule

// File: verilog/bit_serializer.sv
`timescale 1ns/1ps

module bit_serializer #(
    parameter int out_credits = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  huff_pkg::phase_t            phase,
    input  logic                        bit_valid,
    input  logic                        bit_data,
    output logic                        bit_ready,
    output logic                        out_valid,
    output logic [huff_pkg::char_w-1:0] out_data,
    input  logic                        out_credit,
    output logic                        flushed
);

    localparam int cred_w = $clog2(out_credits + 1);

    logic [huff_pkg::char_w-1:0] sh;        // Newest bit at LSB
    logic [3:0]                  fill;      // 0 to 8 bits held
    logic [cred_w-1:0]           credits;
    logic                        has_credit;
    logic                        xfer;
    logic                        send;
    logic                        pad;
    logic [huff_pkg::char_w-1:0] send_byte;

    assign has_credit = (credits != '0);
    assign bit_ready  = (fill != 4'd8);     // Full byte blocks upstream
    assign xfer       = bit_valid && bit_ready;

    always_comb begin
        send      = 1'b0;
        pad       = 1'b0;
        send_byte = sh;
        if (fill == 4'd8) begin
            send = has_credit;              // Byte stalled on credit
        end else if (xfer && fill == 4'd7) begin
            send      = has_credit;
            send_byte = {sh[6:0], bit_data};
        end else if (phase == huff_pkg::flush && fill != 4'd0) begin
            pad       = 1'b1;
            send      = has_credit;
            send_byte = sh << (4'd8 - fill);    // Zero padding below
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill      <= 4'd0;
            credits   <= cred_w'(out_credits);
            out_valid <= 1'b0;
            flushed   <= 1'b0;
        end else begin
            out_valid <= send;
            credits   <= credits - cred_w'(send) + cred_w'(out_credit);
            if (send) begin
                fill <= 4'd0;
            end else if (xfer) begin
                fill <= fill + 4'd1;
            end
            flushed <= (phase == huff_pkg::flush) && !flushed &&
                       ((pad && send) || fill == 4'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            sh <= {sh[6:0], bit_data};
        end
        if (send) begin
            out_data <= send_byte;
        end
    end

    // Sink never returns more than it was given
    assert property (@(posedge clk) disable iff (rst)
        credits <= cred_w'(out_credits));

endmodule

// File: verilog/huff_encoder_top.sv
`timescale 1ns/1ps

module huff_encoder_top #(
    parameter logic [15:0] magic       = 16'h4855,
    parameter int          out_credits = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         tbl_we,
    input  logic [huff_pkg::char_w-1:0]  tbl_addr,
    input  logic [huff_pkg::path_w-1:0]  tbl_path,
    input  logic                         start,
    input  logic [huff_pkg::count_w-1:0] total_chars,
    input  logic                         char_valid,
    input  logic [huff_pkg::char_w-1:0]  char_data,
    output logic                         char_credit,
    output logic                         out_valid,
    output logic [huff_pkg::char_w-1:0]  out_data,
    input  logic                         out_credit,
    output logic                         done
);

    huff_pkg::phase_t            phase;
    logic                        header_done;
    logic                        fin;
    logic                        flushed;
    logic                        head_bit;
    logic                        head_valid;
    logic                        head_last;
    logic                        head_take;
    logic                        lookup;
    logic [huff_pkg::char_w-1:0] char_addr;
    logic [huff_pkg::path_w-1:0] path;
    logic                        path_valid;
    logic                        bit_ready;
    logic                        bit_valid;
    logic                        bit_data;

    encode_ctrl i_ctrl (
        .clk(clk), .rst(rst), .start(start), .header_done(header_done),
        .fin(fin), .flushed(flushed), .phase(phase), .done(done)
    );

    header_emitter #(.magic(magic)) i_header (
        .clk(clk), .rst(rst), .phase(phase), .head_take(head_take),
        .head_bit(head_bit), .head_valid(head_valid), .head_last(head_last)
    );

    code_table i_table (
        .clk(clk), .rst(rst), .tbl_we(tbl_we), .tbl_addr(tbl_addr),
        .tbl_path(tbl_path), .lookup(lookup), .char_addr(char_addr),
        .path(path), .path_valid(path_valid)
    );

    code_translator i_translator (
        .clk(clk), .rst(rst), .phase(phase), .total_chars(total_chars),
        .start(start), .head_bit(head_bit), .head_valid(head_valid),
        .head_last(head_last), .head_take(head_take), .char_valid(char_valid),
        .char_data(char_data), .char_credit(char_credit), .lookup(lookup),
        .char_addr(char_addr), .path(path), .path_valid(path_valid),
        .bit_ready(bit_ready), .bit_valid(bit_valid), .bit_data(bit_data),
        .header_done(header_done), .fin(fin)
    );

    bit_serializer #(.out_credits(out_credits)) i_serializer (
        .clk(clk), .rst(rst), .phase(phase), .bit_valid(bit_valid),
        .bit_data(bit_data), .bit_ready(bit_ready), .out_valid(out_valid),
        .out_data(out_data), .out_credit(out_credit), .flushed(flushed)
    );

endmodule

// File: dv/tb_huff_ref.svh
`ifndef TB_HUFF_REF_SVH
`define TB_HUFF_REF_SVH

logic [huff_pkg::char_w-1:0] ref_acc;       // Reference byte being packed
int                          ref_fill;

// One xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

// Marker one above a code of 1 to 20 random bits
function automatic logic [huff_pkg::path_w-1:0] random_path();
    int                          len;
    logic [huff_pkg::path_w-1:0] mask;
    rng  = xorshift32(rng);
    len  = 1 + int'(rng % 20);
    mask = (128'd1 << len) - 128'd1;
    rng  = xorshift32(rng);
    return (128'd1 << len) | ({96'd0, rng} & mask);
endfunction

function automatic void pack_bit(input logic b);
    ref_acc  = {ref_acc[6:0], b};           // MSB first into the byte
    ref_fill = ref_fill + 1;
    if (ref_fill == 8) begin
        exp_q.push_back(ref_acc);
        ref_fill = 0;
    end
endfunction

// Magic, count, then the bits below each marker, zero padded
function automatic void build_reference(input logic [15:0] mg, input logic [31:0] total);
    logic [47:0]                 head;
    logic [huff_pkg::path_w-1:0] p;
    int                          top;
    exp_q.delete();
    ref_acc  = '0;
    ref_fill = 0;
    head     = {mg, total};
    for (int i = 47; i >= 0; i--) begin
        pack_bit(head[i]);
    end
    foreach (msg[k]) begin
        p   = table_path[msg[k]];
        top = 0;
        for (int i = 0; i < huff_pkg::path_w; i++) begin
            if (p[i]) top = i;              // Marker position
        end
        for (int i = top - 1; i >= 0; i--) begin
            pack_bit(p[i]);
        end
    end
    if (ref_fill != 0) begin
        exp_q.push_back(ref_acc << (8 - ref_fill));
    end
endfunction

`endif

// File: dv/tb_huff_encoder.sv
`timescale 1ns/1ps

module tb_huff_encoder;

    localparam logic [15:0] tb_magic   = 16'hB5C3;
    localparam int          tb_credits = 4;
    localparam int          n_extra    = 3;      // Characters queued behind end of file
    localparam int          max_wait   = 20000;

    logic                         clk;
    logic                         rst;
    logic                         tbl_we;
    logic [huff_pkg::char_w-1:0]  tbl_addr;
    logic [huff_pkg::path_w-1:0]  tbl_path;
    logic                         start;
    logic [huff_pkg::count_w-1:0] total_chars;
    logic                         char_valid;
    logic [huff_pkg::char_w-1:0]  char_data;
    logic                         char_credit;
    logic                         out_valid;
    logic [huff_pkg::char_w-1:0]  out_data;
    logic                         out_credit;
    logic                         done;

    logic [31:0]                  rng;
    logic [31:0]                  sink_rng;
    logic [huff_pkg::path_w-1:0]  table_path [256];
    logic [huff_pkg::char_w-1:0]  msg [$];
    logic [huff_pkg::char_w-1:0]  exp_q [$];
    logic [huff_pkg::char_w-1:0]  got_q [$];
    logic [huff_pkg::char_w-1:0]  src_q [$];
    int                           src_credits;   // Source side
    int                           consumed;      // Credits back to the source
    int                           owed;          // Bytes not yet credited
    int                           reserve;       // Credits the sink keeps back
    logic                         slow_mode;
    int                           dut_credits;   // Monitor copy of DUT credits
    logic                         credit_q;
    int                           mon_char_credits;

    `include "tb_huff_ref.svh"

    huff_encoder_top #(.magic(tb_magic), .out_credits(tb_credits)) i_dut (
        .clk(clk), .rst(rst), .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_path(tbl_path),
        .start(start), .total_chars(total_chars), .char_valid(char_valid),
        .char_data(char_data), .char_credit(char_credit), .out_valid(out_valid),
        .out_data(out_data), .out_credit(out_credit), .done(done)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_byte(input logic [huff_pkg::char_w-1:0] got,
                              input logic [huff_pkg::char_w-1:0] exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: byte %0d is %h, expected %h",
                                $time, idx, got, exp));
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: done is %b, expected %b", $time, got, exp));
        end
    endtask

    // Character source and byte sink, driven after the edge
    always @(posedge clk) begin
        #1;
        if (!rst) begin
            src_credits = src_credits + int'(char_credit);
            consumed    = consumed + int'(char_credit);
            char_valid  = 1'b0;
            if (src_credits > 0 && src_q.size() > 0) begin
                char_valid  = 1'b1;
                char_data   = src_q.pop_front();
                src_credits = src_credits - 1;
            end
            owed = owed + int'(out_valid);
            if (slow_mode && owed > 0 && reserve < tb_credits - 1) begin
                owed    = owed - 1;         // Shrink the window to one credit
                reserve = reserve + 1;
            end else if (!slow_mode) begin
                owed    = owed + reserve;
                reserve = 0;
            end
            sink_rng   = xorshift32(sink_rng);
            out_credit = 1'b0;
            if (owed > 0 && (sink_rng % (slow_mode ? 8 : 3)) == 0) begin
                out_credit = 1'b1;
                owed       = owed - 1;
            end
        end
    end

    // Byte compare and credit bookkeeping at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid) begin
                if (dut_credits == 0) abort_run("Output byte sent without a held credit");
                if (got_q.size() >= exp_q.size()) abort_run("Output byte past the stream end");
                dut_credits = dut_credits - 1;
                check_byte(out_data, exp_q[got_q.size()], got_q.size());
                got_q.push_back(out_data);
            end
            dut_credits      = dut_credits + int'(credit_q);    // Usable one cycle later
            credit_q         = out_credit;
            mon_char_credits = mon_char_credits + int'(char_credit);
            if (mon_char_credits > 1) begin
                abort_run("More character credits returned than characters sent");
            end
            if (char_valid) begin
                if (mon_char_credits == 0) abort_run("Character sent without a credit");
                mon_char_credits = mon_char_credits - 1;
            end
        end
    end

    task automatic run_stream(input int n, input logic new_msg, input logic slow,
                              input int released);
        int          waited;
        logic [31:0] cnt;
        cnt = n;
        if (new_msg) begin
            msg.delete();
            for (int i = 0; i < n; i++) begin
                rng = xorshift32(rng);
                msg.push_back(rng[7:0] == huff_pkg::eof_char ? 8'h00 : rng[7:0]);
            end
        end
        build_reference(tb_magic, cnt);
        slow_mode = slow;
        got_q.delete();
        src_q.delete();                     // Source holds no credit here
        consumed = 0;
        foreach (msg[i]) begin
            src_q.push_back(msg[i]);
        end
        src_q.push_back(huff_pkg::eof_char);
        for (int i = 0; i < n_extra; i++) begin
            src_q.push_back(8'h41 + 8'(i));
        end
        start       = 1'b1;
        total_chars = cnt;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_done(done, 1'b0);
        waited = 0;
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
            if (waited > max_wait) abort_run("Timeout while waiting for done");
        end
        @(posedge clk);
        #1;
        check_done(done, 1'b1);             // Held until the next start
        if (got_q.size() != exp_q.size()) begin
            abort_run($sformatf("MISMATCH at %0t: %0d bytes sent, expected %0d",
                                $time, got_q.size(), exp_q.size()));
        end
        check_byte(got_q[0], tb_magic[15:8], 0);
        check_byte(got_q[1], tb_magic[7:0], 1);
        for (int i = 0; i < 4; i++) begin
            check_byte(got_q[2+i], cnt[31-8*i -: 8], 2 + i);
        end
        if (src_q.size() != n_extra) abort_run("Characters after end of file were consumed");
        if (consumed != n + released) begin
            abort_run($sformatf("MISMATCH at %0t: %0d character credits, expected %0d",
                                $time, consumed, n + released));
        end
    endtask

    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        tbl_we           = 1'b0;
        tbl_addr         = '0;
        tbl_path         = '0;
        start            = 1'b0;
        total_chars      = '0;
        char_valid       = 1'b0;
        char_data        = '0;
        out_credit       = 1'b0;
        rng              = 32'h7a85;
        sink_rng         = 32'h7a85;
        src_credits      = 1;
        consumed         = 0;
        owed             = 0;
        reserve          = 0;
        slow_mode        = 1'b0;
        dut_credits      = tb_credits;
        credit_q         = 1'b0;
        mon_char_credits = 1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int a = 0; a < 256; a++) begin
            table_path[a] = random_path();
            tbl_we        = 1'b1;
            tbl_addr      = 8'(a);
            tbl_path      = table_path[a];
            @(posedge clk);
            #1;
        end
        tbl_we = 1'b0;
        run_stream(40, 1'b1, 1'b0, 0);
        run_stream(40, 1'b0, 1'b1, 1);      // Same message, single credit window
        run_stream(25, 1'b1, 1'b0, 1);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: huff_encoder.f
+incdir+dv
verilog/huff_pkg.sv
verilog/encode_ctrl.sv
verilog/header_emitter.sv
verilog/code_table.sv
verilog/code_translator.sv
verilog/bit_serializer.sv
verilog/huff_encoder_top.sv
dv/tb_huff_encoder.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_huff_encoder
FLIST     ?= huff_encoder.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
HDRS := dv/tb_huff_ref.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
